/* sources.f */
rtl/actPkg.sv
rtl/actLoopIf.sv
rtl/actCmdIn.sv
rtl/actLoopCtrl.sv
rtl/actRowStream.sv
rtl/actFetchTop.sv
bench/actFetchTb.sv

/* Bender.yml */
package:
  name: act_fetch

sources:
  - files:
      - rtl/actPkg.sv
      - rtl/actLoopIf.sv
      - rtl/actCmdIn.sv
      - rtl/actLoopCtrl.sv
      - rtl/actRowStream.sv
      - rtl/actFetchTop.sv
  - target: test
    files:
      - bench/actFetchTb.sv

/* bench/actFetchTb.sv */
// Activation fetch testbench with buffer preload, random requests, loop model and assertions
`timescale 1ns/10ps

module actFetchTb import actPkg::*; ();

    localparam int actWidth  = 16;
    localparam int addrWidth = 10;
    localparam int entW      = addrWidth + 4;
    localparam logic [actWidth-1:0] fillMask = 16'hA5C3;

    logic clk, rst_n, start, getAct, memWrEn;
    logic [LEN_ROW_WIDTH-1:0] cfgLenRow;
    logic [BLK_WIDTH-1:0]     cfgDepBlk, cfgNumBlk;
    logic [FRAME_WIDTH-1:0]   cfgNumFrm;
    logic [PATCH_WIDTH-1:0]   cfgNumPat;
    logic [LAYER_WIDTH-1:0]   cfgNumLay;
    logic [addrWidth-1:0]     memWrAddr;
    logic [actWidth-1:0]      memWrData, actData;
    logic busy, actValid, firstRow, lastRow, lastBlk, done;

    // Reference model state
    logic             modelBusy = 1'b0;
    logic             accepted;
    logic             started = 1'b0;
    logic [entW-1:0]  expQ[$];
    logic [addrWidth-1:0] headAddr = '0;
    logic             headFirst = 1'b0, headLast = 1'b0, headBlk = 1'b0, headEnd = 1'b0;
    int mLen = 0, mDep = 0, mNumBlk = 1;
    int mAct = 0, mRow = 0, mBlk = 0;
    int issued = 0, total = 0, beats = 0;
    logic doneSeen = 1'b0, timedOut = 1'b0;
    int dataErrs = 0, flagErrs = 0, timingErrs = 0, otherErrs = 0;
    int seed;

    actFetchTop #(.actWidth(actWidth), .addrWidth(addrWidth)) UUT (
        .clk(clk), .rst_n(rst_n), .start(start), .cfgLenRow(cfgLenRow),
        .cfgDepBlk(cfgDepBlk), .cfgNumBlk(cfgNumBlk), .cfgNumFrm(cfgNumFrm),
        .cfgNumPat(cfgNumPat), .cfgNumLay(cfgNumLay), .getAct(getAct),
        .memWrEn(memWrEn), .memWrAddr(memWrAddr), .memWrData(memWrData),
        .busy(busy), .actValid(actValid), .actData(actData), .firstRow(firstRow),
        .lastRow(lastRow), .lastBlk(lastBlk), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Buffer word for an address, every address bit shows up in the data
    function automatic logic [actWidth-1:0] fillWord(input logic [addrWidth-1:0] a);
        return actWidth'({a[5:0], a}) ^ fillMask;
    endfunction

    // A start counts when idle, a getAct while fetches remain
    assign accepted = modelBusy ? (getAct && issued < total) : start;

    //========================================================================
    // Reference loop model
    //========================================================================

    // Frames, patches and layers only repeat the block walk
    task stepLoops;
        if (mAct < mLen) begin
            mAct++;
        end else begin
            mAct = 0;
            if (mRow < mLen) begin
                mRow++;
            end else begin
                mRow = 0;
                mBlk = (mBlk < mNumBlk - 1) ? mBlk + 1 : 0;
            end
        end
    endtask

    always @(posedge clk or negedge rst_n) begin : refModel
        logic            acc;
        logic            wasBusy;
        logic [entW-1:0] ent;
        int              addr;
        if (!rst_n) begin
            modelBusy <= 1'b0;
            issued = 0;
            total = 0;
            expQ.delete();
        end else begin
            acc = accepted;
            wasBusy = modelBusy;
            // Retire the beat seen on this edge
            if (actValid) begin
                void'(expQ.pop_front());
                beats++;
                if (done) begin
                    doneSeen = 1'b1;
                end
            end
            // Busy drops one edge after the final request
            if (wasBusy && issued == total) begin
                modelBusy <= 1'b0;
            end
            if (acc) begin
                if (!wasBusy) begin
                    mLen = cfgLenRow;
                    mDep = cfgDepBlk;
                    mNumBlk = cfgNumBlk;
                    total = (mLen + 1) * (mLen + 1) * mNumBlk * cfgNumFrm * cfgNumPat
                            * cfgNumLay;
                    mAct = 0;
                    mRow = 0;
                    mBlk = 0;
                    issued = 0;
                    modelBusy <= 1'b1;
                end
                issued++;
                addr = (mBlk * mDep + mRow * (mLen + 1) + mAct) % (1 << addrWidth);
                ent = {addr[addrWidth-1:0], mAct == 0, mAct == mLen,
                       mRow == mLen && mAct == 0, issued == total};
                expQ.push_back(ent);
                stepLoops();
            end
            if (expQ.size() > 0) begin
                ent = expQ[0];
                headAddr  <= ent[entW-1:4];
                headFirst <= ent[3];
                headLast  <= ent[2];
                headBlk   <= ent[1];
                headEnd   <= ent[0];
            end
        end
    end

    //========================================================================
    // Assertions
    //========================================================================

    aIdle: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !(busy || actValid || done || firstRow || lastRow || lastBlk))
        else begin
            timingErrs++;
            $display("FAILED at %0t: outputs active before the first start", $time);
        end

    // Fixed two cycle latency, both ways
    aLatency: assert property (@(posedge clk) disable iff (!rst_n)
        accepted |-> ##2 actValid)
        else begin
            timingErrs++;
            $display("FAILED at %0t: no actValid 2 cycles after request", $time);
        end

    aNoExtra: assert property (@(posedge clk) disable iff (!rst_n)
        actValid |-> $past(accepted, 2))
        else begin
            timingErrs++;
            $display("FAILED at %0t: actValid without accepted request", $time);
        end

    aData: assert property (@(posedge clk) disable iff (!rst_n)
        actValid |-> actData == fillWord(headAddr))
        else begin
            dataErrs++;
            $display("FAILED at %0t: actData %h, expected %h at addr %0d", $time,
                     actData, fillWord(headAddr), headAddr);
        end

    aFlags: assert property (@(posedge clk) disable iff (!rst_n)
        actValid |-> {firstRow, lastRow, lastBlk} == {headFirst, headLast, headBlk})
        else begin
            flagErrs++;
            $display("FAILED at %0t: flags %b, expected %b at addr %0d", $time,
                     {firstRow, lastRow, lastBlk}, {headFirst, headLast, headBlk}, headAddr);
        end

    aDone: assert property (@(posedge clk) disable iff (!rst_n)
        actValid |-> done == headEnd)
        else begin
            flagErrs++;
            $display("FAILED at %0t: done %b, expected %b", $time, done, headEnd);
        end

    // Flags only ride on a beat
    aQuiet: assert property (@(posedge clk) disable iff (!rst_n)
        !actValid |-> !(done || firstRow || lastRow || lastBlk))
        else begin
            flagErrs++;
            $display("FAILED at %0t: flag or done high without actValid", $time);
        end

    aBusy: assert property (@(posedge clk) disable iff (!rst_n)
        busy == modelBusy)
        else begin
            timingErrs++;
            $display("FAILED at %0t: busy %b, expected %b", $time, busy, modelBusy);
        end

    //========================================================================
    // Stimulus
    //========================================================================

    task preloadBuffer;
        for (int a = 0; a < (1 << addrWidth); a++) begin
            memWrEn = 1'b1;
            memWrAddr = addrWidth'(a);
            memWrData = fillWord(addrWidth'(a));
            @(posedge clk);
            #1;
        end
        memWrEn = 1'b0;
    endtask

    task automatic runConfig(input int len, dep, nBlk, nFrm, nPat, nLay);
        int expBeats;
        int cyc;
        expBeats = (len + 1) * (len + 1) * nBlk * nFrm * nPat * nLay;
        {cfgLenRow, cfgDepBlk, cfgNumBlk} = {4'(len), 8'(dep), 8'(nBlk)};
        {cfgNumFrm, cfgNumPat, cfgNumLay} = {4'(nFrm), 4'(nPat), 4'(nLay)};
        beats = 0;
        doneSeen = 1'b0;
        start = 1'b1;
        started = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        cyc = 0;
        while (!doneSeen && cyc < 4000) begin
            getAct = (($random(seed) & 32'h7fff_ffff) % 100) < 60;
            // Stray start with a different config, must be ignored
            start = (cyc == 6) && busy;
            if (start) begin
                cfgNumBlk = 8'd99;
            end
            @(posedge clk);
            #1;
            cyc++;
        end
        start = 1'b0;
        if (!doneSeen) begin
            otherErrs++;
            timedOut = 1'b1;
            getAct = 1'b0;
            $display("Timeout: done did not arrive within %0d cycles", cyc);
            return;
        end
        // Late requests after the run
        repeat (12) begin
            getAct = (($random(seed) & 32'h7fff_ffff) % 100) < 60;
            @(posedge clk);
            #1;
        end
        getAct = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        aBeats: assert (beats == expBeats && expQ.size() == 0)
            else begin
                otherErrs++;
                $display("FAILED at %0t: %0d beats, expected %0d", $time, beats, expBeats);
            end
    endtask

    initial begin
        seed = 32'h74c8_2e03;
        {rst_n, start, getAct, memWrEn} = 4'b0;
        {cfgLenRow, cfgDepBlk, cfgNumBlk, cfgNumFrm, cfgNumPat, cfgNumLay} = '0;
        memWrAddr = '0;
        memWrData = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        preloadBuffer();
        runConfig(0, 4, 3, 1, 1, 1);
        if (!timedOut) begin
            runConfig(2, 16, 2, 1, 1, 1);
        end
        // Block walk wraps past the end of the buffer
        if (!timedOut) begin
            runConfig(1, 250, 6, 2, 2, 2);
        end
        repeat (4) @(posedge clk);
        $display("Errors: data %0d, flags %0d, timing %0d, other %0d",
                 dataErrs, flagErrs, timingErrs, otherErrs);
        if (dataErrs + flagErrs + timingErrs + otherErrs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* rtl/actFetchTop.sv */
// Activation fetch top level with input stage, loop controller and buffer output stage
`timescale 1ns/10ps

module actFetchTop import actPkg::*; #(
    parameter int actWidth  = 16,
    parameter int addrWidth = 10
) (
    input  logic                     clk,
    input  logic                     rst_n,
    // Run control
    input  logic                     start,
    input  logic [LEN_ROW_WIDTH-1:0] cfgLenRow,
    input  logic [BLK_WIDTH-1:0]     cfgDepBlk,
    input  logic [BLK_WIDTH-1:0]     cfgNumBlk,
    input  logic [FRAME_WIDTH-1:0]   cfgNumFrm,
    input  logic [PATCH_WIDTH-1:0]   cfgNumPat,
    input  logic [LAYER_WIDTH-1:0]   cfgNumLay,
    input  logic                     getAct,
    // Buffer load
    input  logic                     memWrEn,
    input  logic [addrWidth-1:0]     memWrAddr,
    input  logic [actWidth-1:0]      memWrData,
    // Activation stream
    output logic                     busy,
    output logic                     actValid,
    output logic [actWidth-1:0]      actData,
    output logic                     firstRow,
    output logic                     lastRow,
    output logic                     lastBlk,
    output logic                     done
);

    // Config ports gathered into one struct
    actCfg_t cfgIn;
    actCfg_t cmdCfg;
    logic    cmdFetch;
    logic    cmdClear;
    logic    loopLastAll;

    assign cfgIn = '{lenRow: cfgLenRow, depBlk: cfgDepBlk, numBlk: cfgNumBlk,
                     numFrm: cfgNumFrm, numPat: cfgNumPat, numLay: cfgNumLay};

    // Controller to output stage bus
    actLoopIf #(.addrWidth(addrWidth)) loopBus ();

    actCmdIn uCmdIn (
        .clk(clk), .rst_n(rst_n), .start(start), .getAct(getAct), .cfgIn(cfgIn),
        .lastAll(loopLastAll), .cfg(cmdCfg), .fetch(cmdFetch), .clear(cmdClear),
        .busy(busy)
    );

    actLoopCtrl #(.addrWidth(addrWidth)) uLoopCtrl (
        .clk(clk), .rst_n(rst_n), .cfg(cmdCfg), .fetchIn(cmdFetch), .clear(cmdClear),
        .lastAll(loopLastAll), .loop(loopBus.ctrl)
    );

    actRowStream #(.actWidth(actWidth), .addrWidth(addrWidth)) uRowStream (
        .clk(clk), .rst_n(rst_n), .loop(loopBus.stream), .memWrEn(memWrEn),
        .memWrAddr(memWrAddr), .memWrData(memWrData), .actValid(actValid),
        .firstRow(firstRow), .lastRow(lastRow), .lastBlk(lastBlk), .done(done),
        .actData(actData)
    );

endmodule

/* rtl/actRowStream.sv */
// Output stage with activation buffer, host write port, registered read and flag alignment
`timescale 1ns/10ps

module actRowStream #(
    parameter int actWidth  = 16,
    parameter int addrWidth = 10
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // Fetch strobe, address and flags from the loop controller
    actLoopIf.stream             loop,
    // Host buffer load port
    input  logic                 memWrEn,
    input  logic [addrWidth-1:0] memWrAddr,
    input  logic [actWidth-1:0]  memWrData,
    // Activation beat to the consumer
    output logic                 actValid,
    output logic                 firstRow,
    output logic                 lastRow,
    output logic                 lastBlk,
    output logic                 done,
    output logic [actWidth-1:0]  actData
);

    // One word per buffer address
    localparam int memDepth = 2 ** addrWidth;

    logic [actWidth-1:0] actMem [memDepth];

    //==========================================================================
    // Activation buffer
    //==========================================================================

    // Synchronous write from the host
    always_ff @(posedge clk) begin
        if (memWrEn) begin
            actMem[memWrAddr] <= memWrData;
        end
    end

    // Registered read, data held between fetches
    always_ff @(posedge clk) begin
        if (loop.fetch) begin
            actData <= actMem[loop.addr];
        end
    end

    //==========================================================================
    // Flag alignment
    //==========================================================================

    // Flags registered with the read so they line up with actData
    // Only set on a real beat, low in between
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            actValid <= 1'b0;
            firstRow <= 1'b0;
            lastRow  <= 1'b0;
            lastBlk  <= 1'b0;
            done     <= 1'b0;
        end else begin
            actValid <= loop.fetch;
            firstRow <= loop.fetch & loop.firstRow;
            lastRow  <= loop.fetch & loop.lastRow;
            lastBlk  <= loop.fetch & loop.lastBlk;
            // Done rides on the last beat
            done     <= loop.fetch & loop.lastAll;
        end
    end

endmodule

/* rtl/actLoopCtrl.sv */
// Nested loop controller with activation to layer counters, boundary flags and buffer address
`timescale 1ns/10ps

module actLoopCtrl import actPkg::*; #(
    parameter int addrWidth = 10
) (
    input  logic    clk,
    input  logic    rst_n,
    input  actCfg_t cfg,
    // Registered fetch strobe from the input stage
    input  logic    fetchIn,
    // Zero all counters at an accepted start
    input  logic    clear,
    // Final fetch of the run, back to the input stage
    output logic    lastAll,
    actLoopIf.ctrl  loop
);

    // Loop counters, innermost first
    logic [LEN_ROW_WIDTH-1:0] cntAct;
    logic [LEN_ROW_WIDTH-1:0] cntRow;
    logic [BLK_WIDTH-1:0]     cntBlk;
    logic [FRAME_WIDTH-1:0]   cntFrm;
    logic [PATCH_WIDTH-1:0]   cntPat;
    logic [LAYER_WIDTH-1:0]   cntLay;

    // Running address bases
    logic [addrWidth-1:0] rowBase;
    logic [addrWidth-1:0] blkBase;
    logic [addrWidth-1:0] rowStep;
    logic [addrWidth-1:0] blkStep;

    // Counter at its limit
    logic actEnd, rowEnd, blkEnd, frmEnd, patEnd, layEnd;
    // Loop level completes on this fetch
    logic rowDone, blkDone, frmDone, patDone, layDone;
    logic actFirst;

    //==========================================================================
    // Limit and carry decode
    //==========================================================================

    // Square block, rows per block equal activations per row
    assign actEnd = cntAct == cfg.lenRow;
    assign rowEnd = cntRow == cfg.lenRow;
    // Outer counts are real values
    assign blkEnd = cntBlk == cfg.numBlk - 1'b1;
    assign frmEnd = cntFrm == cfg.numFrm - 1'b1;
    assign patEnd = cntPat == cfg.numPat - 1'b1;
    assign layEnd = cntLay == cfg.numLay - 1'b1;

    // Carry chain
    assign rowDone = actEnd;
    assign blkDone = rowDone & rowEnd;
    assign frmDone = blkDone & blkEnd;
    assign patDone = frmDone & frmEnd;
    assign layDone = patDone & patEnd;
    assign lastAll = layDone & layEnd;

    assign actFirst = cntAct == '0;

    // Strides, wrapped to the buffer size
    assign rowStep = addrWidth'(cfg.lenRow) + addrWidth'(1);
    assign blkStep = addrWidth'(cfg.depBlk);

    //==========================================================================
    // Counters
    //==========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cntAct <= '0;
            cntRow <= '0;
            cntBlk <= '0;
            cntFrm <= '0;
            cntPat <= '0;
            cntLay <= '0;
        end else if (clear) begin
            cntAct <= '0;
            cntRow <= '0;
            cntBlk <= '0;
            cntFrm <= '0;
            cntPat <= '0;
            cntLay <= '0;
        end else if (fetchIn) begin
            cntAct <= actEnd ? '0 : cntAct + 1'b1;
            if (rowDone) begin
                cntRow <= rowEnd ? '0 : cntRow + 1'b1;
            end
            if (blkDone) begin
                cntBlk <= blkEnd ? '0 : cntBlk + 1'b1;
            end
            if (frmDone) begin
                cntFrm <= frmEnd ? '0 : cntFrm + 1'b1;
            end
            if (patDone) begin
                cntPat <= patEnd ? '0 : cntPat + 1'b1;
            end
            // All counters back at zero after the final fetch
            if (layDone) begin
                cntLay <= layEnd ? '0 : cntLay + 1'b1;
            end
        end
    end

    // Row base steps per row, block base steps per block
    // Block sequence restarts at every frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rowBase <= '0;
            blkBase <= '0;
        end else if (clear) begin
            rowBase <= '0;
            blkBase <= '0;
        end else if (fetchIn) begin
            if (blkDone) begin
                rowBase <= '0;
            end else if (rowDone) begin
                rowBase <= rowBase + rowStep;
            end
            if (frmDone) begin
                blkBase <= '0;
            end else if (blkDone) begin
                blkBase <= blkBase + blkStep;
            end
        end
    end

    // Bus outputs, combinational from the counters
    assign loop.fetch    = fetchIn;
    assign loop.addr     = blkBase + rowBase + addrWidth'(cntAct);
    assign loop.firstRow = actFirst;
    assign loop.lastRow  = actEnd;
    // Last row of the block, taken at its first activation
    assign loop.lastBlk  = rowEnd & actFirst;
    assign loop.lastAll  = lastAll;

endmodule

/* rtl/actCmdIn.sv */
// Command input stage with config latch, busy state and registered fetch strobe
`timescale 1ns/10ps

module actCmdIn import actPkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    // Run control from the host
    input  logic    start,
    input  logic    getAct,
    input  actCfg_t cfgIn,
    // Final fetch flag from the loop controller
    input  logic    lastAll,
    // Latched config for the loop controller
    output actCfg_t cfg,
    output logic    fetch,
    output logic    clear,
    output logic    busy
);

    //==========================================================================
    // Request qualification
    //==========================================================================

    // Start accepted only while idle
    logic startOk;
    // Final fetch is on the bus this cycle
    logic runEnd;
    // Consumer request turned into a fetch next cycle
    logic reqOk;

    assign startOk = start & ~busy;
    assign runEnd  = fetch & lastAll;

    // Nothing requested past the final fetch
    assign reqOk = busy & getAct & ~runEnd;

    // Counters clear on the same edge that latches the config
    // so the first fetch sees a zeroed loop
    assign clear = startOk;

    //==========================================================================
    // State
    //==========================================================================

    // Config held for the whole run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (startOk) begin
            cfg <= cfgIn;
        end
    end

    // Busy from accepted start until the final fetch has gone out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (startOk) begin
            busy <= 1'b1;
        end else if (runEnd) begin
            busy <= 1'b0;
        end
    end

    // Registered fetch strobe, one cycle after start or getAct
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch <= 1'b0;
        end else begin
            fetch <= startOk | reqOk;
        end
    end

endmodule

/* rtl/actLoopIf.sv */
// Loop controller to output stage bus with fetch strobe, buffer address and boundary flags
`timescale 1ns/10ps

interface actLoopIf #(
    parameter int addrWidth = 10
);

    // One-cycle read strobe
    logic                 fetch;
    // Buffer word address for this fetch
    logic [addrWidth-1:0] addr;
    // Row and block boundary flags
    logic                 firstRow;
    logic                 lastRow;
    logic                 lastBlk;
    // Final fetch of the run
    logic                 lastAll;

    // Loop controller side
    modport ctrl (
        output fetch, addr, firstRow, lastRow, lastBlk, lastAll
    );

    // Buffer read side
    modport stream (
        input fetch, addr, firstRow, lastRow, lastBlk, lastAll
    );

endinterface

/* rtl/actPkg.sv */
// Activation fetch package with loop config field widths and the config struct
package actPkg;

    //==========================================================================
    // Config field widths
    //==========================================================================

    // Row length minus one, also the number of rows in a square block
    localparam int LEN_ROW_WIDTH = 4;
    // Block count and block address stride
    localparam int BLK_WIDTH = 8;
    // Outer loop counts, real values of at least 1
    localparam int FRAME_WIDTH = 4;
    localparam int PATCH_WIDTH = 4;
    localparam int LAYER_WIDTH = 4;

    // Loop config, latched once per run
    typedef struct packed {
        // Activations per row minus one
        logic [LEN_ROW_WIDTH-1:0] lenRow;
        // Buffer address stride between blocks
        logic [BLK_WIDTH-1:0]     depBlk;
        // Blocks per frame
        logic [BLK_WIDTH-1:0]     numBlk;
        // Frames per patch
        logic [FRAME_WIDTH-1:0]   numFrm;
        // Patches per layer
        logic [PATCH_WIDTH-1:0]   numPat;
        // Layers per run
        logic [LAYER_WIDTH-1:0]   numLay;
    } actCfg_t;

endpackage
